//--- common/gfx_cfg.svh
`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

// screen geometry in pixels
`define GFX_SCREEN_W 320
`define GFX_SCREEN_H 240

// framebuffer word addresses, one buffer per base
`define GFX_FB_BASE0 32'h0000_0000
`define GFX_FB_BASE1 32'h0002_0000

`endif

//--- common/apb_pkg.sv
package apb_pkg;

	typedef logic [3:0] apb_addr_t;

	localparam apb_addr_t reg_start  = 4'h0;	// start corner
	localparam apb_addr_t reg_end    = 4'h4;	// end corner
	localparam apb_addr_t reg_color  = 4'h8;
	localparam apb_addr_t reg_cmd    = 4'hC;	// write starts a command
	localparam apb_addr_t reg_status = 4'h0;	// read side of offset 0

	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [7:0]  reject_count;	// saturates at 255
		logic [5:0]  rsvd_lo;
		logic        front_buf;
		logic        busy;
	} status_t;

endpackage

//--- common/draw_pkg.sv
package draw_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;

	typedef logic [31:0] color_t;

	// opcode lives in bits 2:0 of the command register
	typedef enum logic [2:0] {
		op_nop   = 3'd0,
		op_pixel = 3'd1,
		op_rect  = 3'd2,
		op_flip  = 3'd3
	} draw_op_t;

	typedef logic [31:0] fb_addr_t;

endpackage

//--- logic/apb_slave.sv
`timescale 1ns/1ns

module apb_slave (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  apb_pkg::apb_addr_t paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	input  apb_pkg::status_t   status,
	output logic [16:0]        start_pt,
	output logic [16:0]        end_pt,
	output draw_pkg::color_t   color,
	output logic [31:0]        cmd_word,
	output logic               cmd_valid
);
	import apb_pkg::*;

	logic wr_en;
	logic rd_en;

	// no wait states, access phase always completes
	assign wr_en = psel & penable & pwrite;
	assign rd_en = psel & ~pwrite;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			start_pt  <= '0;
			end_pt    <= '0;
			color     <= '0;
			cmd_word  <= '0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (wr_en)
			begin
				case (paddr)
					reg_start: start_pt <= pwdata[16:0];	// y in 16:9, x in 8:0
					reg_end:   end_pt   <= pwdata[16:0];
					reg_color: color    <= pwdata;
					reg_cmd:
					begin
						cmd_word  <= pwdata;
						cmd_valid <= 1'b1;	// one cycle strobe
					end
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		prdata = '0;
		if (rd_en && paddr == reg_status)
			prdata = status;
	end

endmodule

//--- logic/cmd_decode.sv
`timescale 1ns/1ns

module cmd_decode (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  logic [31:0]        cmd_word,
	output logic               draw_req,
	output logic               flip_req,
	output draw_pkg::draw_op_t draw_op
);
	import draw_pkg::*;

	draw_op_t opcode;
	logic     is_draw;
	logic     is_flip;

	assign opcode = draw_op_t'(cmd_word[2:0]);

	always_comb
	begin
		is_draw = 1'b0;
		is_flip = 1'b0;
		case (opcode)
			op_pixel, op_rect: is_draw = 1'b1;
			op_flip:           is_flip = 1'b1;
			default: ;	// nop and undefined codes fall through
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			draw_req <= 1'b0;
			flip_req <= 1'b0;
			draw_op  <= op_nop;
		end
		else
		begin
			draw_req <= cmd_valid & is_draw;
			flip_req <= cmd_valid & is_flip;
			if (cmd_valid && is_draw)
				draw_op <= opcode;	// held until next draw
		end
	end

endmodule

//--- logic/frame_controller.sv
`timescale 1ns/1ns

module frame_controller (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             draw_req,
	input  logic             flip_req,
	input  logic             render_done,
	output logic             render_start,
	output logic             back_buf,
	output logic             front_buf,
	output apb_pkg::status_t status
);
	import apb_pkg::*;

	logic       busy;
	logic [7:0] reject_count;
	logic       drop;

	assign drop = busy & (draw_req | flip_req);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy         <= 1'b0;
			render_start <= 1'b0;
			back_buf     <= 1'b0;
			front_buf    <= 1'b0;
		end
		else
		begin
			render_start <= 1'b0;
			if (busy)
			begin
				if (render_done)
					busy <= 1'b0;
			end
			else if (draw_req)
			begin
				busy         <= 1'b1;
				render_start <= 1'b1;
				back_buf     <= ~front_buf;	// draw into the hidden buffer
			end
			else if (flip_req)
				front_buf <= ~front_buf;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			reject_count <= '0;
		else if (drop && reject_count != 8'hff)
			reject_count <= reject_count + 8'd1;
	end

	always_comb
	begin
		status              = '0;
		status.busy         = busy;
		status.front_buf    = front_buf;
		status.reject_count = reject_count;
	end

endmodule

//--- render/render_engine.sv
`timescale 1ns/1ns

`include "gfx_cfg.svh"

module render_engine (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               render_start,
	input  draw_pkg::draw_op_t draw_op,
	input  logic [16:0]        start_pt,
	input  logic [16:0]        end_pt,
	input  draw_pkg::color_t   color,
	output logic               pix_valid,
	output draw_pkg::coord_x_t pix_x,
	output draw_pkg::coord_y_t pix_y,
	output draw_pkg::color_t   pix_color,
	output logic               render_done
);
	import draw_pkg::*;

	typedef enum logic {st_idle, st_walk} state_t;

	state_t   state;
	coord_x_t sx, ex, min_x, max_x;
	coord_y_t sy, ey, min_y, max_y;
	coord_x_t lo_x, hi_x, cur_x;
	coord_y_t hi_y, cur_y;
	logic     last_x;
	logic     last_y;

	// order the corners, a pixel uses its start corner twice
	always_comb
	begin
		sx    = start_pt[8:0];
		sy    = start_pt[16:9];
		ex    = (draw_op == op_pixel) ? sx : end_pt[8:0];
		ey    = (draw_op == op_pixel) ? sy : end_pt[16:9];
		min_x = (sx < ex) ? sx : ex;
		max_x = (sx < ex) ? ex : sx;
		min_y = (sy < ey) ? sy : ey;
		max_y = (sy < ey) ? ey : sy;
	end

	assign last_x = (cur_x == hi_x);
	assign last_y = (cur_y == hi_y);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			cur_x <= '0;
			cur_y <= '0;
		end
		else
		begin
			case (state)
				st_idle:
					if (render_start)
					begin
						state <= st_walk;
						cur_x <= min_x;
						cur_y <= min_y;
					end
				st_walk:
					if (!last_x)
						cur_x <= cur_x + 9'd1;
					else if (!last_y)
					begin
						cur_x <= lo_x;	// back to row start
						cur_y <= cur_y + 8'd1;
					end
					else
						state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (render_start && state == st_idle)
		begin
			lo_x      <= min_x;
			hi_x      <= max_x;
			hi_y      <= max_y;
			pix_color <= color;
		end
	end

	assign pix_valid   = (state == st_walk);
	assign pix_x       = cur_x;
	assign pix_y       = cur_y;
	assign render_done = pix_valid & last_x & last_y;	// with final pixel

endmodule

//--- render/pixel_writer.sv
`timescale 1ns/1ns

`include "gfx_cfg.svh"

module pixel_writer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               pix_valid,
	input  draw_pkg::coord_x_t pix_x,
	input  draw_pkg::coord_y_t pix_y,
	input  draw_pkg::color_t   pix_color,
	input  logic               back_buf,
	output logic               fb_we,
	output draw_pkg::fb_addr_t fb_addr,
	output draw_pkg::color_t   fb_data
);
	import draw_pkg::*;

	localparam fb_addr_t screen_w = `GFX_SCREEN_W;
	localparam fb_addr_t base0    = `GFX_FB_BASE0;
	localparam fb_addr_t base1    = `GFX_FB_BASE1;

	fb_addr_t base;
	fb_addr_t row_off;
	fb_addr_t addr_next;

	always_comb
	begin
		base      = back_buf ? base1 : base0;
		row_off   = fb_addr_t'(pix_y) * screen_w;
		addr_next = base + row_off + fb_addr_t'(pix_x);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fb_we <= 1'b0;
		else
			fb_we <= pix_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			fb_addr <= addr_next;
			fb_data <= pix_color;
		end
	end

endmodule

//--- logic/gfx_top.sv
`timescale 1ns/1ns

module gfx_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  apb_pkg::apb_addr_t paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               fb_we,
	output draw_pkg::fb_addr_t fb_addr,
	output draw_pkg::color_t   fb_data,
	output logic               front_buf
);
	import apb_pkg::*;
	import draw_pkg::*;

	status_t     status;
	logic [16:0] start_pt;
	logic [16:0] end_pt;
	color_t      color;
	logic [31:0] cmd_word;
	logic        cmd_valid;
	logic        draw_req;
	logic        flip_req;
	draw_op_t    draw_op;
	logic        render_start;
	logic        render_done;
	logic        back_buf;
	logic        pix_valid;
	coord_x_t    pix_x;
	coord_y_t    pix_y;
	color_t      pix_color;

	apb_slave apb_slave_inst (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.status(status),
		.start_pt(start_pt), .end_pt(end_pt), .color(color),
		.cmd_word(cmd_word), .cmd_valid(cmd_valid)
	);

	cmd_decode cmd_decode_inst (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_word(cmd_word),
		.draw_req(draw_req), .flip_req(flip_req), .draw_op(draw_op)
	);

	frame_controller frame_controller_inst (
		.clk(clk), .rst_n(rst_n),
		.draw_req(draw_req), .flip_req(flip_req), .render_done(render_done),
		.render_start(render_start), .back_buf(back_buf),
		.front_buf(front_buf), .status(status)
	);

	render_engine render_engine_inst (
		.clk(clk), .rst_n(rst_n),
		.render_start(render_start), .draw_op(draw_op),
		.start_pt(start_pt), .end_pt(end_pt), .color(color),
		.pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
		.pix_color(pix_color), .render_done(render_done)
	);

	pixel_writer pixel_writer_inst (
		.clk(clk), .rst_n(rst_n),
		.pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
		.pix_color(pix_color), .back_buf(back_buf),
		.fb_we(fb_we), .fb_addr(fb_addr), .fb_data(fb_data)
	);

endmodule

//--- tb/gfx_tb.sv
`timescale 1ns/1ns

`include "gfx_cfg.svh"

module gfx_tb;
	import apb_pkg::*;
	import draw_pkg::*;

	typedef struct {
		coord_x_t x0;
		coord_y_t y0;
		coord_x_t x1;
		coord_y_t y1;
		color_t   color;
		draw_op_t op;
		bit       reject;	// sent while the row before still draws
	} row_t;

	localparam int num_rows    = 9;
	localparam int cmd_latency = 5;	// reg_cmd access edge to edge taking first fb_we

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        fb_we;
	fb_addr_t    fb_addr;
	color_t      fb_data;
	logic        front_buf;

	row_t        rows[num_rows];
	fb_addr_t    exp_addr[$];
	color_t      exp_data[$];
	int          exp_cyc[$];
	fb_addr_t    act_addr[$];
	color_t      act_data[$];
	int          act_cyc[$];
	int          cyc = 0;
	int          last_access;
	int          limit_cycles = 0;
	logic [31:0] rng;
	logic        model_front;
	logic [7:0]  model_rejects;

	gfx_top gfx_top_inst (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.fb_we(fb_we), .fb_addr(fb_addr), .fb_data(fb_data),
		.front_buf(front_buf)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// stamped with the edge at which memory takes the strobe
	always @(negedge clk)
	begin
		if (rst_n === 1'b1 && fb_we === 1'b1)
		begin
			act_addr.push_back(fb_addr);
			act_data.push_back(fb_data);
			act_cyc.push_back(cyc + 1);
		end
	end

	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);	// 100 ns each
		abort_run("timeout: watchdog expired before the table finished");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_addr(input int idx, input fb_addr_t got, input fb_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail: fb_addr write %0d got %h expected %h", idx, got, exp));
	endtask

	task automatic check_color(input int idx, input color_t got, input color_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail: fb_data write %0d got %h expected %h", idx, got, exp));
	endtask

	task automatic check_status(input status_t got, input status_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail: status got %h expected %h", got, exp));
	endtask

	task automatic check_timing(input int idx, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("Fail: fb_we cycle of write %0d got %h expected %h", idx, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic row_t random_rect();
		row_t r;
		rng = xorshift32(rng);
		r.x0 = 9'(rng[7:0]) + 9'd40;
		r.x1 = r.x0 - 9'(rng[9:8]);	// end corner left of start
		r.y0 = 8'(rng[15:12]) + 8'd100;
		r.y1 = r.y0 + 8'(rng[17:16]);
		rng = xorshift32(rng);
		r.color = rng;
		r.op = op_rect;
		r.reject = 1'b0;
		return r;
	endfunction

	function automatic int pixel_count(input row_t r);
		int w;
		int h;
		w = (r.x0 > r.x1) ? int'(r.x0 - r.x1) : int'(r.x1 - r.x0);
		h = (r.y0 > r.y1) ? int'(r.y0 - r.y1) : int'(r.y1 - r.y0);
		if (r.op == op_rect)
			return (w + 1) * (h + 1);
		return (r.op == op_pixel) ? 1 : 0;
	endfunction

	task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#5;
		penable = 1'b1;
		@(posedge clk);	// access edge
		#5;
		psel        = 1'b0;
		penable     = 1'b0;
		last_access = cyc;
	endtask

	task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#5;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;	// mid access phase
		@(posedge clk);
		#5;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		coord_x_t ex;
		coord_y_t ey;
		int       x;
		int       y;
		int       k;
		fb_addr_t base;
		if (r.reject)
		begin
			apb_write(reg_cmd, {29'd0, r.op});	// corners of the running draw already latched
			if (model_rejects != 8'hff)
				model_rejects = model_rejects + 8'd1;
		end
		apb_write(reg_start, {15'd0, r.y0, r.x0});
		apb_write(reg_end, {15'd0, r.y1, r.x1});
		apb_write(reg_color, r.color);
		if (r.reject)
			return;
		apb_write(reg_cmd, {29'd0, r.op});
		if (r.op == op_flip)
			model_front = ~model_front;
		if (r.op != op_pixel && r.op != op_rect)
			return;
		ex   = (r.op == op_pixel) ? r.x0 : r.x1;
		ey   = (r.op == op_pixel) ? r.y0 : r.y1;
		base = model_front ? `GFX_FB_BASE0 : `GFX_FB_BASE1;	// hidden buffer
		k    = 0;
		for (y = int'((r.y0 < ey) ? r.y0 : ey); y <= int'((r.y0 < ey) ? ey : r.y0); y++)
			for (x = int'((r.x0 < ex) ? r.x0 : ex); x <= int'((r.x0 < ex) ? ex : r.x0); x++)
			begin
				exp_addr.push_back(base + fb_addr_t'(y) * `GFX_SCREEN_W + fb_addr_t'(x));
				exp_data.push_back(r.color);
				exp_cyc.push_back(last_access + cmd_latency + k);
				k++;
			end
	endtask

	task automatic drain_and_check();
		int          wait_left;
		logic [31:0] rd;
		status_t     exp_st;
		wait_left = exp_addr.size() + 20;
		while (act_addr.size() < exp_addr.size() && wait_left > 0)
		begin
			@(posedge clk);
			wait_left--;
		end
		if (act_addr.size() < exp_addr.size())
			abort_run($sformatf("missing writes: saw %0d of %0d", act_addr.size(), exp_addr.size()));
		for (int i = 0; i < exp_addr.size(); i++)
		begin
			check_addr(i, act_addr[i], exp_addr[i]);
			check_color(i, act_data[i], exp_data[i]);
			check_timing(i, act_cyc[i], exp_cyc[i]);
		end
		exp_st              = '0;
		exp_st.front_buf    = model_front;
		exp_st.reject_count = model_rejects;
		@(posedge clk);
		#5;
		apb_read(reg_status, rd);	// busy should be gone by now
		check_status(status_t'(rd), exp_st);
		if (front_buf !== model_front)
			abort_run($sformatf("Fail: front_buf got %h expected %h", front_buf, model_front));
		repeat (6) @(posedge clk);
		#5;
		if (act_addr.size() != exp_addr.size())
			abort_run("extra write strobe after the expected ones");
		exp_addr.delete();
		exp_data.delete();
		exp_cyc.delete();
		act_addr.delete();
		act_data.delete();
		act_cyc.delete();
	endtask

	initial
	begin
		logic [31:0] rd;
		int          total;
		clk           = 1'b0;
		rst_n         = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		model_front   = 1'b0;
		model_rejects = 8'd0;
		rng           = 32'hfb06;
		rows[0] = '{9'd5, 8'd3, 9'd5, 8'd3, 32'h00ff_0000, op_pixel, 1'b0};
		rows[1] = '{9'd12, 8'd9, 9'd9, 8'd7, 32'h0000_ff00, op_rect, 1'b0};	// swapped corners
		rows[2] = '{9'd0, 8'd0, 9'd1, 8'd1, 32'h0000_00ff, op_rect, 1'b1};
		rows[3] = '{9'd0, 8'd0, 9'd0, 8'd0, 32'h0, op_flip, 1'b0};
		rows[4] = '{9'd319, 8'd239, 9'd319, 8'd239, 32'hdead_beef, op_pixel, 1'b0};
		rows[5] = random_rect();
		rows[6] = '{9'd0, 8'd0, 9'd0, 8'd0, 32'h0, op_nop, 1'b0};
		rows[7] = '{9'd0, 8'd0, 9'd0, 8'd0, 32'h0, op_flip, 1'b0};
		rows[8] = random_rect();
		total = 0;
		for (int i = 0; i < num_rows; i++)
			total += pixel_count(rows[i]) + 40;
		limit_cycles = total;
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		repeat (4) @(posedge clk);
		#5;
		if (act_addr.size() != 0)
			abort_run("write strobe seen right after reset");
		apb_read(reg_status, rd);
		check_status(status_t'(rd), status_t'(32'd0));
		for (int i = 0; i < num_rows; i++)
		begin
			apply_row(rows[i]);
			if (i + 1 == num_rows || !rows[i + 1].reject)
				drain_and_check();
		end
		repeat (10) @(posedge clk);
		if (act_addr.size() == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			abort_run("extra write strobe after the last table row");
	end

endmodule

//--- project.f
+incdir+common
common/apb_pkg.sv
common/draw_pkg.sv
logic/apb_slave.sv
logic/cmd_decode.sv
logic/frame_controller.sv
render/render_engine.sv
render/pixel_writer.sv
logic/gfx_top.sv
tb/gfx_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = gfx_tb
RTL_TOP   = gfx_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
